// ==== source/bp_pkg.sv ====
package bp_pkg;

    localparam int XLEN           = 32;
    localparam int PHT_INDEX_BITS = 12;
    localparam int PHT_DEPTH      = 1 << PHT_INDEX_BITS;
    localparam int PHT_INDEX_LSB  = 2;  // pc[1:0] is always zero for rv32i

    typedef logic [1:0]                ctr_t;   // 0 snt, 1 wnt, 2 wt, 3 st
    typedef logic [PHT_INDEX_BITS-1:0] pht_index_t;

    localparam ctr_t CTR_RESET = 2'd0;  // strongly not taken

    typedef enum logic [1:0] {
        CLS_NONE = 2'd0,
        CLS_JAL  = 2'd1,
        CLS_JALR = 2'd2,
        CLS_COND = 2'd3
    } br_class_t;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1_data;  // only used by jalr
        br_class_t       cls;
    } fetch_req_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] next_pc;
    } pred_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [2:0]      funct3;
        br_class_t       cls;
        logic            predicted_taken;  // carried down from fetch
    } resolve_req_t;

    typedef struct packed {
        logic            mispredict;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic       valid;
        pht_index_t index;
        logic       taken;
    } train_t;

    // next pc for a given class and direction, shared by fetch and execute
    function automatic logic [XLEN-1:0] calc_next_pc(
        input br_class_t       cls,
        input logic [XLEN-1:0] pc,
        input logic [XLEN-1:0] imm,
        input logic [XLEN-1:0] rs1_data,
        input logic            taken
    );
        logic [XLEN-1:0] npc;
        case (cls)
            CLS_JAL:  npc = pc + imm;
            CLS_JALR: npc = (rs1_data + imm) & ~XLEN'(1);  // jalr drops bit 0
            CLS_COND: npc = taken ? pc + imm : pc + XLEN'(4);
            default:  npc = pc + XLEN'(4);
        endcase
        return npc;
    endfunction

endpackage

// ==== source/bht_clear_fsm.sv ====
`timescale 1ns/100ps

module bht_clear_fsm (
    input  logic clk,
    input  logic rst,
    input  logic last,      // final table index is being written
    output logic clearing,
    output logic ready
);

    typedef enum logic {
        CLEAR = 1'b0,
        RUN   = 1'b1
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CLEAR: begin
                if (last) begin
                    state_d = RUN;  // last entry goes in on this edge
                end
            end
            RUN: begin
                state_d = RUN;  // stays here until the next reset
            end
            default: begin
                state_d = CLEAR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= CLEAR;
        end else begin
            state_q <= state_d;
        end
    end

    assign clearing = (state_q == CLEAR);
    assign ready    = (state_q == RUN);

endmodule

// ==== source/bht_index_counter.sv ====
`timescale 1ns/100ps

module bht_index_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                clearing,
    output bp_pkg::pht_index_t  clear_index,
    output logic                last
);

    import bp_pkg::*;

    localparam pht_index_t LAST_INDEX = pht_index_t'(PHT_DEPTH - 1);

    pht_index_t index_q;

    // wraps back to zero after the last entry, then holds there
    always_ff @(posedge clk) begin
        if (rst) begin
            index_q <= '0;
        end else if (clearing) begin
            index_q <= index_q + pht_index_t'(1);
        end
    end

    assign clear_index = index_q;
    assign last        = clearing && (index_q == LAST_INDEX);

endmodule

// ==== source/pattern_history_table.sv ====
`timescale 1ns/100ps

module pattern_history_table (
    input  logic                clk,
    input  logic                clearing,
    input  bp_pkg::pht_index_t  clear_index,
    input  bp_pkg::pht_index_t  rd_index,
    output bp_pkg::ctr_t        rd_ctr,
    input  bp_pkg::train_t      train
);

    import bp_pkg::*;

    ctr_t table_q [PHT_DEPTH];  // written by the clear sequencer and by training

    ctr_t train_cur;
    ctr_t train_upd;

    // fetch read port, sees the value before any write on this edge
    assign rd_ctr = table_q[rd_index];

    // saturating step for the counter under training
    always_comb begin
        train_cur = table_q[train.index];
        train_upd = train_cur;
        if (train.taken) begin
            if (train_cur != 2'd3) begin
                train_upd = train_cur + 2'd1;
            end
        end else begin
            if (train_cur != 2'd0) begin
                train_upd = train_cur - 2'd1;
            end
        end
    end

    // clearing owns the write port, training only runs after ready
    always_ff @(posedge clk) begin
        if (clearing) begin
            table_q[clear_index] <= CTR_RESET;
        end else if (train.valid) begin
            table_q[train.index] <= train_upd;
        end
    end

endmodule

// ==== source/next_pc_unit.sv ====
`timescale 1ns/100ps

module next_pc_unit (
    input  logic                fetch_valid,
    input  bp_pkg::fetch_req_t  fetch,
    input  logic                ready,
    output bp_pkg::pht_index_t  rd_index,
    input  bp_pkg::ctr_t        rd_ctr,
    output logic                pred_valid,
    output bp_pkg::pred_t       pred
);

    import bp_pkg::*;

    logic pred_taken;

    // pc[13:2] picks the counter, upper bits alias
    assign rd_index = fetch.pc[PHT_INDEX_LSB +: PHT_INDEX_BITS];

    always_comb begin
        case (fetch.cls)
            CLS_JAL,
            CLS_JALR: pred_taken = 1'b1;
            CLS_COND: pred_taken = rd_ctr[1];  // weakly or strongly taken
            default:  pred_taken = 1'b0;
        endcase
    end

    assign pred_valid   = fetch_valid && ready;
    assign pred.taken   = pred_taken;
    assign pred.next_pc = calc_next_pc(fetch.cls, fetch.pc, fetch.imm,
                                       fetch.rs1_data, pred_taken);

endmodule

// ==== source/branch_resolver.sv ====
`timescale 1ns/100ps

module branch_resolver (
    input  logic                  resolve_valid,
    input  bp_pkg::resolve_req_t  resolve,
    input  logic                  ready,
    output logic                  redirect_valid,
    output bp_pkg::redirect_t     redirect,
    output bp_pkg::train_t        train
);

    import bp_pkg::*;

    logic            fire;
    logic            cond_taken;
    logic            actual_taken;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] actual_pc;

    assign fire = resolve_valid && ready;  // strobes before ready are dropped

    assign eq   = (resolve.rs1_data == resolve.rs2_data);
    assign lt_s = ($signed(resolve.rs1_data) < $signed(resolve.rs2_data));
    assign lt_u = (resolve.rs1_data < resolve.rs2_data);

    always_comb begin
        case (resolve.funct3)
            F3_BEQ:  cond_taken = eq;
            F3_BNE:  cond_taken = !eq;
            F3_BLT:  cond_taken = lt_s;
            F3_BGE:  cond_taken = !lt_s;
            F3_BLTU: cond_taken = lt_u;
            F3_BGEU: cond_taken = !lt_u;
            default: cond_taken = 1'b0;  // 010 and 011 are not branches
        endcase
    end

    // jumps always go, plain instructions never do
    always_comb begin
        case (resolve.cls)
            CLS_JAL,
            CLS_JALR: actual_taken = 1'b1;
            CLS_COND: actual_taken = cond_taken;
            default:  actual_taken = 1'b0;
        endcase
    end

    assign actual_pc = calc_next_pc(resolve.cls, resolve.pc, resolve.imm,
                                    resolve.rs1_data, actual_taken);

    assign redirect_valid      = fire;
    assign redirect.mispredict = (actual_taken != resolve.predicted_taken);
    assign redirect.pc         = actual_pc;

    assign train.valid = fire && (resolve.cls == CLS_COND);  // only counters for branches
    assign train.index = resolve.pc[PHT_INDEX_LSB +: PHT_INDEX_BITS];
    assign train.taken = actual_taken;

endmodule

// ==== source/branch_predict_top.sv ====
`timescale 1ns/100ps

module branch_predict_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_valid,
    input  bp_pkg::fetch_req_t    fetch,
    input  logic                  resolve_valid,
    input  bp_pkg::resolve_req_t  resolve,
    output logic                  pred_valid,
    output bp_pkg::pred_t         pred,
    output logic                  redirect_valid,
    output bp_pkg::redirect_t     redirect,
    output logic                  ready
);

    import bp_pkg::*;

    logic       clearing;
    logic       last;
    pht_index_t clear_index;
    pht_index_t rd_index;
    ctr_t       rd_ctr;
    train_t     train;

    bht_clear_fsm u_clear_fsm (
        .clk      (clk),
        .rst      (rst),
        .last     (last),
        .clearing (clearing),
        .ready    (ready)
    );

    bht_index_counter u_index_counter (
        .clk         (clk),
        .rst         (rst),
        .clearing    (clearing),
        .clear_index (clear_index),
        .last        (last)
    );

    pattern_history_table u_pht (
        .clk         (clk),
        .clearing    (clearing),
        .clear_index (clear_index),
        .rd_index    (rd_index),
        .rd_ctr      (rd_ctr),
        .train       (train)
    );

    next_pc_unit u_next_pc (
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .ready       (ready),
        .rd_index    (rd_index),
        .rd_ctr      (rd_ctr),
        .pred_valid  (pred_valid),
        .pred        (pred)
    );

    branch_resolver u_resolver (
        .resolve_valid  (resolve_valid),
        .resolve        (resolve),
        .ready          (ready),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .train          (train)
    );

endmodule

// ==== tests/branch_properties.sv ====
`timescale 1ns/100ps

module branch_properties (
    input  logic                clk,
    input  logic                rst,
    input  logic                ready,
    input  logic                pred_valid,
    input  logic                redirect_valid,
    input  bp_pkg::fetch_req_t  fetch,
    input  bp_pkg::pred_t       pred
);

    import bp_pkg::*;

    int unsigned error_count = 0;  // read by the testbench at the end

    // nothing leaves the predictor while the table is being cleared
    a_strobe_gated: assert property (@(posedge clk) disable iff (rst)
        !ready |-> (!pred_valid && !redirect_valid))
        else begin
            $error("pred_valid or redirect_valid high while ready is low");
            error_count++;
        end

    a_ready_sticky: assert property (@(posedge clk) disable iff (rst)
        ready |=> ready)
        else begin
            $error("ready fell after it had risen");
            error_count++;
        end

    // jalr may land on bit 1, the others never do
    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        (pred_valid && (fetch.cls == CLS_NONE || fetch.cls == CLS_COND))
            |-> (pred.next_pc[1:0] == 2'b00))
        else begin
            $error("predicted next pc is not word aligned");
            error_count++;
        end

endmodule

bind branch_predict_top branch_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .ready          (ready),
    .pred_valid     (pred_valid),
    .redirect_valid (redirect_valid),
    .fetch          (fetch),
    .pred           (pred)
);

// ==== tests/branch_checker.sv ====
`timescale 1ns/100ps

module branch_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               ready,
    input  logic               pred_valid,
    input  bp_pkg::pred_t      pred,
    input  logic               redirect_valid,
    input  bp_pkg::redirect_t  redirect,
    input  logic               check_en,   // one table entry is on the bus
    input  int                 entry,
    input  logic [3:0]         group,
    input  logic               exp_pred_valid,
    input  bp_pkg::pred_t      exp_pred,
    input  logic               exp_redirect_valid,
    input  bp_pkg::redirect_t  exp_redirect,
    input  logic               report,     // print the closing counts
    output int                 pass_count,
    output int                 fail_count
);

    import bp_pkg::*;

    int   ready_edges;
    logic ready_seen;

    task automatic compare_field(input string what, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want, inout bit ok);
        if (got !== want) begin
            $display("[FAIL] %0t: entry %0d %s is %h, expected %h",
                     $time, entry, what, got, want);
            ok = 1'b0;
        end
    endtask

    always @(posedge clk) begin : sample
        bit ok;
        if (rst) begin
            pass_count  = 0;
            fail_count  = 0;
            ready_edges = 0;
            ready_seen  = 1'b0;
        end else begin
            // ready is sampled before this edge updates it
            if (!ready_seen) begin
                ready_edges = ready_edges + 1;
                if (ready === 1'b1) begin
                    ready_seen = 1'b1;
                    if (ready_edges != PHT_DEPTH + 1) begin
                        $display("[FAIL] %0t: ready seen %0d edges after reset, expected %0d",
                                 $time, ready_edges, PHT_DEPTH + 1);
                        fail_count = fail_count + 1;
                    end
                end
            end
            if (check_en) begin
                ok = 1'b1;
                compare_field("pred_valid", pred_valid, exp_pred_valid, ok);
                if (exp_pred_valid) begin
                    compare_field("pred.taken", pred.taken, exp_pred.taken, ok);
                    compare_field("pred.next_pc", pred.next_pc, exp_pred.next_pc, ok);
                end
                compare_field("redirect_valid", redirect_valid, exp_redirect_valid, ok);
                if (exp_redirect_valid) begin
                    compare_field("redirect.mispredict", redirect.mispredict,
                                  exp_redirect.mispredict, ok);
                    compare_field("redirect.pc", redirect.pc, exp_redirect.pc, ok);
                end
                if (ok) begin
                    pass_count = pass_count + 1;
                    $display("entry %0d (group %0d) ok", entry, group);
                end else begin
                    fail_count = fail_count + 1;
                end
            end
            if (report) begin
                $display("entries passed %0d, failures %0d", pass_count, fail_count);
            end
        end
    end

endmodule

// ==== tests/tb_branch_predict.sv ====
`timescale 1ns/100ps

module tb_branch_predict;

    import bp_pkg::*;

    // how the two compare operands of a row relate
    typedef enum logic [2:0] {
        REL_EQ,   // equal
        REL_LTS,  // less signed, greater unsigned
        REL_LTU,  // less unsigned, greater signed
        REL_LT,   // less either way
        REL_GT    // greater either way
    } rel_t;

    typedef struct packed {
        logic            valid;
        br_class_t       cls;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic            exp_taken;
    } fetch_step_t;

    typedef struct packed {
        logic            valid;
        br_class_t       cls;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [2:0]      funct3;
        rel_t            rel;
        logic            predicted;
        logic            exp_taken;  // actual direction from the compare
    } resolve_step_t;

    typedef struct packed {
        logic [3:0]    group;
        fetch_step_t   f;
        resolve_step_t r;
    } row_t;

    logic         clk;
    logic         rst;
    logic         fetch_valid;
    fetch_req_t   fetch;
    logic         resolve_valid;
    resolve_req_t resolve;
    logic         pred_valid;
    pred_t        pred;
    logic         redirect_valid;
    redirect_t    redirect;
    logic         ready;

    logic         check_en;
    int           entry_id;
    logic [3:0]   group_id;
    logic         exp_pred_valid;
    pred_t        exp_pred;
    logic         exp_redirect_valid;
    redirect_t    exp_redirect;
    logic         report;
    int           pass_count;
    int           fail_count;

    row_t         rows[$];
    int           seed;
    logic         table_built;

    branch_predict_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .resolve_valid  (resolve_valid),
        .resolve        (resolve),
        .pred_valid     (pred_valid),
        .pred           (pred),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .ready          (ready)
    );

    branch_checker u_checker (
        .clk                (clk),
        .rst                (rst),
        .ready              (ready),
        .pred_valid         (pred_valid),
        .pred               (pred),
        .redirect_valid     (redirect_valid),
        .redirect           (redirect),
        .check_en           (check_en),
        .entry              (entry_id),
        .group              (group_id),
        .exp_pred_valid     (exp_pred_valid),
        .exp_pred           (exp_pred),
        .exp_redirect_valid (exp_redirect_valid),
        .exp_redirect       (exp_redirect),
        .report             (report),
        .pass_count         (pass_count),
        .fail_count         (fail_count)
    );

    // jalr clears bit 0, everything else is pc relative
    function automatic logic [XLEN-1:0] expected_target(input br_class_t cls,
            input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
            input logic [XLEN-1:0] rs1, input logic taken);
        logic [XLEN-1:0] sum;
        sum = rs1 + imm;
        if (cls == CLS_JALR) begin
            return {sum[XLEN-1:1], 1'b0};
        end
        return taken ? pc + imm : pc + 32'd4;
    endfunction

    task automatic make_operands(input rel_t rel, output logic [XLEN-1:0] a,
                                 output logic [XLEN-1:0] b);
        logic [XLEN-1:0] r1;
        logic [XLEN-1:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        case (rel)
            REL_EQ: begin
                a = r1;
                b = r1;
            end
            REL_LTS: begin
                a = r1 | 32'h8000_0000;
                b = r2 & 32'h7fff_ffff;
            end
            REL_LTU: begin
                a = r1 & 32'h7fff_ffff;
                b = r2 | 32'h8000_0000;
            end
            REL_LT: begin
                a = r1 & 32'h3fff_ffff;
                b = a + 32'd1 + (r2 & 32'hffff);
            end
            default: begin
                b = r1 & 32'h3fff_ffff;
                a = b + 32'd1 + (r2 & 32'hffff);
            end
        endcase
    endtask

    task automatic add_row(input logic [3:0] group, input fetch_step_t f,
                           input resolve_step_t r);
        rows.push_back('{group, f, r});
    endtask

    task automatic build_table();
        // group 1, untrained counters predict not taken
        add_row(4'd1, '{1'b1, CLS_COND, 32'h0000_1000, 32'h40, 1'b0}, '0);
        add_row(4'd1, '{1'b1, CLS_COND, 32'h0000_1104, 32'hffff_ff00, 1'b0}, '0);
        add_row(4'd1, '{1'b1, CLS_COND, 32'h0000_6000, 32'h80, 1'b0}, '0);
        // group 2, jumps and plain instructions
        add_row(4'd2, '{1'b1, CLS_JAL, 32'h0000_2000, 32'h100, 1'b1}, '0);
        add_row(4'd2, '{1'b1, CLS_JAL, 32'h0000_3000, 32'hffff_fff8, 1'b1}, '0);
        add_row(4'd2, '{1'b1, CLS_JALR, 32'h0000_3100, 32'h11, 1'b1}, '0);
        add_row(4'd2, '{1'b1, CLS_JALR, 32'h0000_3200, 32'hffff_ffff, 1'b1}, '0);
        add_row(4'd2, '{1'b1, CLS_NONE, 32'h0000_4000, 32'h0, 1'b0}, '0);
        add_row(4'd2, '0, '0);  // idle cycle
        // group 3, every funct3 with signed and unsigned corner operands
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h800, 32'h20, F3_BEQ, REL_EQ, 1'b0, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h804, 32'h20, F3_BEQ, REL_LTS, 1'b0, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h808, 32'h20, F3_BNE, REL_EQ, 1'b1, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h80c, 32'h20, F3_BNE, REL_GT, 1'b1, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h810, 32'h20, F3_BLT, REL_LTS, 1'b0, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h814, 32'h20, F3_BLT, REL_LTU, 1'b1, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h818, 32'h20, F3_BLT, REL_GT, 1'b0, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h81c, 32'h20, F3_BGE, REL_LTU, 1'b1, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h820, 32'h20, F3_BGE, REL_LTS, 1'b1, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h824, 32'h20, F3_BGE, REL_EQ, 1'b0, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h828, 32'h20, F3_BLTU, REL_LTU, 1'b0, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h82c, 32'h20, F3_BLTU, REL_LTS, 1'b0, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h830, 32'h20, F3_BLTU, REL_LT, 1'b1, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h834, 32'h20, F3_BGEU, REL_LTS, 1'b0, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h838, 32'h20, F3_BGEU, REL_EQ, 1'b1, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_COND, 32'h83c, 32'h20, F3_BGEU, REL_LT, 1'b1, 1'b0});
        add_row(4'd3, '0, '{1'b1, CLS_JAL, 32'h3000, 32'h100, F3_BEQ, REL_EQ, 1'b1, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_JALR, 32'h3100, 32'h24, F3_BEQ, REL_EQ, 1'b1, 1'b1});
        add_row(4'd3, '0, '{1'b1, CLS_NONE, 32'h3200, 32'h0, F3_BEQ, REL_EQ, 1'b1, 1'b0});
        // group 4, training at 0x6000, counter walks 0 1 2 3 3 2 1
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b0},
                '{1'b1, CLS_COND, 32'h6000, 32'h80, F3_BEQ, REL_EQ, 1'b0, 1'b1});
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b0},
                '{1'b1, CLS_COND, 32'h6000, 32'h80, F3_BEQ, REL_EQ, 1'b0, 1'b1});
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b1},
                '{1'b1, CLS_COND, 32'h6000, 32'h80, F3_BNE, REL_GT, 1'b1, 1'b1});
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b1},
                '{1'b1, CLS_COND, 32'h6000, 32'h80, F3_BGE, REL_LTU, 1'b1, 1'b1});
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b1},
                '{1'b1, CLS_COND, 32'h6000, 32'h80, F3_BEQ, REL_LTS, 1'b1, 1'b0});
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b1},
                '{1'b1, CLS_COND, 32'h6000, 32'h80, F3_BLTU, REL_LTS, 1'b1, 1'b0});
        add_row(4'd4, '{1'b1, CLS_COND, 32'h6000, 32'h80, 1'b0}, '0);
        // group 5, pcs above bit 13 alias, pcs inside 13..2 do not
        add_row(4'd5, '{1'b1, CLS_COND, 32'h8000_6000, 32'h80, 1'b0},
                '{1'b1, CLS_COND, 32'h0000_a000, 32'h80, F3_BEQ, REL_EQ, 1'b0, 1'b1});
        add_row(4'd5, '{1'b1, CLS_COND, 32'h0000_6000, 32'h80, 1'b1}, '0);
        add_row(4'd5, '{1'b1, CLS_COND, 32'h0000_4000, 32'h80, 1'b0}, '0);
        add_row(4'd5, '{1'b1, CLS_COND, 32'h0000_6004, 32'h80, 1'b0}, '0);
        add_row(4'd5, '{1'b1, CLS_COND, 32'h0000_e000, 32'h80, 1'b1}, '0);
        // group 6, a fetch in the training cycle sees the old counter
        add_row(4'd6, '{1'b1, CLS_COND, 32'h1000, 32'h40, 1'b0},
                '{1'b1, CLS_COND, 32'h1000, 32'h40, F3_BNE, REL_LT, 1'b0, 1'b1});
        add_row(4'd6, '{1'b1, CLS_COND, 32'h1000, 32'h40, 1'b0},
                '{1'b1, CLS_COND, 32'h1000, 32'h40, F3_BLT, REL_LT, 1'b0, 1'b1});
        add_row(4'd6, '{1'b1, CLS_COND, 32'h1000, 32'h40, 1'b1}, '0);
    endtask

    task automatic apply_row(input row_t row, input int idx);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        make_operands(row.r.rel, a, b);
        fetch_valid           = row.f.valid;
        fetch.pc              = row.f.pc;
        fetch.imm             = row.f.imm;
        fetch.rs1_data        = $random(seed);  // jalr base
        fetch.cls             = row.f.cls;
        resolve_valid         = row.r.valid;
        resolve.pc            = row.r.pc;
        resolve.imm           = row.r.imm;
        resolve.rs1_data      = a;
        resolve.rs2_data      = b;
        resolve.funct3        = row.r.funct3;
        resolve.cls           = row.r.cls;
        resolve.predicted_taken = row.r.predicted;
        exp_pred_valid        = row.f.valid;
        exp_pred.taken        = row.f.exp_taken;
        exp_pred.next_pc      = expected_target(row.f.cls, row.f.pc, row.f.imm,
                                                fetch.rs1_data, row.f.exp_taken);
        exp_redirect_valid    = row.r.valid;
        exp_redirect.mispredict = (row.r.exp_taken != row.r.predicted);
        exp_redirect.pc       = expected_target(row.r.cls, row.r.pc, row.r.imm, a,
                                                row.r.exp_taken);
        check_en              = 1'b1;
        entry_id              = idx;
        group_id              = row.group;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        int limit;
        cycles = 0;
        wait (table_built === 1'b1);
        limit = 16 + PHT_DEPTH + rows.size() + 100;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (ready !== 1'b1) begin
            $display("timeout: ready never rose within %0d cycles", limit);
        end else begin
            $display("timeout: the run never finished within %0d cycles", limit);
        end
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed               = 32'h779c_eaaa;
        rst                = 1'b1;
        fetch_valid        = 1'b0;
        fetch              = '0;
        resolve_valid      = 1'b0;
        resolve            = '0;
        check_en           = 1'b0;
        entry_id           = 0;
        group_id           = '0;
        exp_pred_valid     = 1'b0;
        exp_pred           = '0;
        exp_redirect_valid = 1'b0;
        exp_redirect       = '0;
        report             = 1'b0;
        table_built        = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // strobes during clearing, a taken branch at 0x6000 must not train
        fetch_valid   = 1'b1;
        fetch         = '{32'h6000, 32'h80, 32'h0, CLS_COND};
        resolve_valid = 1'b1;
        resolve       = '{32'h6000, 32'h80, 32'h5, 32'h5, F3_BEQ, CLS_COND, 1'b0};
        while (ready !== 1'b1) @(negedge clk);
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i], i);
            @(negedge clk);
        end
        check_en      = 1'b0;
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
        report        = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (fail_count == 0 && u_dut.u_props.error_count == 0 &&
            pass_count == rows.size()) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/bp_pkg.sv
source/bht_clear_fsm.sv
source/bht_index_counter.sv
source/pattern_history_table.sv
source/next_pc_unit.sv
source/branch_resolver.sv
source/branch_predict_top.sv
tests/branch_properties.sv
tests/branch_checker.sv
tests/tb_branch_predict.sv
